//--- bench/sd_readout_bridge_patterns.hex
// One entry per token, up to 64 bits. Entries 0 to 4 are command arguments,
// then DatIn words to fill every stage, words written after the first
// readout, and one CMD6 block whose word 8 carries the access mode in 11:8
@0
// Echo payloads, 56 bits
123456789abcde
f0e1d2c3b4a596
// LEDSet arguments, LED value in the low nibble
abcdef0123456a
00000000000005
// Command code that is not defined
5a
@5
00ff 01fe 02fd 03fc 04fb 05fa 06f9 07f8 08f7 09f6 0af5 0bf4 0cf3 0df2 0ef1 0ff0
10ef 11ee 12ed 13ec 14eb 15ea 16e9 17e8 18e7 19e6 1ae5 1be4 1ce3 1de2 1ee1 1fe0
20df 21de 22dd 23dc 24db 25da 26d9 27d8 28d7 29d6 2ad5 2bd4 2cd3 2dd2 2ed1 2fd0
30cf 31ce 32cd 33cc 34cb 35ca 36c9 37c8 38c7 39c6 3ac5 3bc4 3cc3 3dc2 3ec1 3fc0
40bf 41be 42bd 43bc 44bb 45ba 46b9 47b8 48b7 49b6 4ab5 4bb4 4cb3 4db2 4eb1 4fb0
50af 51ae 52ad 53ac 54ab 55aa 56a9 57a8 58a7 59a6 5aa5 5ba4 5ca3 5da2 5ea1 5fa0
609f 619e 629d 639c 649b 659a 6699 6798 6897 6996 6a95 6b94 6c93 6d92 6e91 6f90
708f 718e 728d 738c 748b 758a 7689 7788 7887 7986 7a85 7b84 7c83 7d82 7e81 7f80
@85
9000 9111 9222 9333 9444 9555 9666 9777 9888 9999 9aaa 9bbb 9ccc 9ddd 9eee 9fff
@95
e000 e101 e202 e303 e404 e505 e606 e707 53c8 e909 eaaa ebbb eccc eddd eeee efff

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ====================
// Error counters
// ====================
int value_errors = 0;   // Wrong DUT values
int other_errors = 0;   // Missing strobes, stray words, timeout

// Failure that is not a value compare
task automatic note_failure(input string what);
    other_errors++;
    $display("ERROR at %0t ns: %s", $time, what);
endtask

// ====================
// Compare tasks
// ====================
task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
endtask

// Full 64-bit response, error bit included
task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
endtask

task automatic check_led(input string name, input led_t got, input led_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
endtask

`endif

//--- bench/tb_sd_readout_bridge.sv
`timescale 1ns/100ps

module tb_sd_readout_bridge import sd_bridge_pkg::*; ();

    localparam int StageCount = 8;
    localparam int StageWords = 16;
    localparam int ReadThresh = StageCount / 2;
    localparam int BurstWords = ReadThresh * StageWords;

    // Entry positions in the patterns file
    localparam int EchoBase    = 0;    // Two Echo payloads
    localparam int LedBase     = 2;    // Two LEDSet arguments
    localparam int BadTypeIdx  = 4;    // Unknown command code
    localparam int DataBase    = 5;    // Enough words to fill every stage
    localparam int DataWords   = StageCount * StageWords;
    localparam int ResumeBase  = DataBase + DataWords;
    localparam int ResumeWords = StageWords;
    localparam int Cmd6Base    = ResumeBase + ResumeWords;
    localparam int Cmd6Words   = StageWords;
    localparam int PatEntries  = Cmd6Base + Cmd6Words;

    // ====================
    // Run length
    // ====================
    localparam int ResetCycles = 16;
    localparam int CmdCount    = 13;
    localparam int IdleChecks  = 2 * StageWords;
    // Up to two cycles per written word and one per read word
    localparam int TestCycles  = ResetCycles + 2 * (DataWords + ResumeWords + Cmd6Words)
                               + 2 * BurstWords + 8 * CmdCount + 2 * IdleChecks;
    localparam int CycleLimit  = 2 * TestCycles;

    logic  sd_datInWrite_clk;
    logic  spi_rst_;
    logic  datin_rst;
    logic  datin_trigger;
    word_t datin_data;
    logic  datin_ready;
    logic  cmd_valid;
    msg_t  cmd_word;
    logic  resp_valid;
    resp_t resp_word;
    led_t  led;
    logic  readout_ready;
    logic  readout_valid;
    word_t readout_data;

    logic [63:0]  pat_mem [PatEntries];
    word_t        expect_q [$];   // Accepted words in write order
    logic [31:0]  lfsr_state;
    int           cycle_count;
    int           block_words;    // Words accepted since the last block start
    led_t         led_model;
    access_mode_t mode_model;

    `include "tb_checks.svh"

    sd_readout_bridge #(
        .StageCount(StageCount),
        .StageWords(StageWords),
        .ReadThresh(ReadThresh)
    ) sd_readout_bridge_i (.*);

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #2 sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CycleLimit) begin
            @(posedge sd_datInWrite_clk);
            cycle_count++;
        end
        note_failure($sformatf("run did not finish within %0d cycles", CycleLimit));
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("test failed");
        $finish;
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bit(output logic b);
        lfsr_state = galois_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    // Status layout with the error bit on top and the access mode lowest
    function automatic resp_t status_word(input logic dr, input logic rr,
                                          input logic [7:0] cnt, input access_mode_t am);
        return {1'b0, dr, rr, cnt, am, 49'd0};
    endfunction

    task automatic send_command(input logic [7:0] code, input logic [55:0] arg,
                                output resp_t resp);
        @(negedge sd_datInWrite_clk);
        if (resp_valid) note_failure("resp_valid high before the command");
        cmd_valid = 1'b1;
        cmd_word  = msg_t'({code, arg});
        @(negedge sd_datInWrite_clk);
        cmd_valid = 1'b0;
        if (!resp_valid) note_failure($sformatf("no response one clock after type %h", code));
        resp = resp_word;
    endtask

    task automatic pulse_datin_rst();
        @(negedge sd_datInWrite_clk);
        datin_rst = 1'b1;
        @(negedge sd_datInWrite_clk);
        datin_rst = 1'b0;
        expect_q.delete();
        block_words = 0;
    endtask

    // Holds each word until datin_ready lets it in
    task automatic write_words(input int first, input int count);
        logic gap;
        for (int i = 0; i < count; i++) begin
            random_bit(gap);
            if (gap) begin
                @(negedge sd_datInWrite_clk);
                datin_trigger = 1'b0;
            end
            @(negedge sd_datInWrite_clk);
            datin_trigger = 1'b1;
            datin_data    = pat_mem[first + i][15:0];
            while (!datin_ready) @(negedge sd_datInWrite_clk);
            expect_q.push_back(datin_data);
            if (block_words == Cmd6WordIndex) mode_model = datin_data[11:8];
            block_words++;
        end
        @(negedge sd_datInWrite_clk);
        datin_trigger = 1'b0;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge sd_datInWrite_clk);
            if (readout_valid) note_failure("readout_valid high with no burst running");
        end
    endtask

    task automatic collect_burst(input int count);
        int    seen;
        word_t exp;
        seen = 0;
        while (seen < count) begin
            @(negedge sd_datInWrite_clk);
            if (readout_valid) begin
                if (expect_q.size() == 0) begin
                    note_failure("readout word with no written word left");
                end else begin
                    exp = expect_q.pop_front();
                    check_word("readout_data", readout_data, exp);
                end
                seen++;
            end
        end
        expect_idle(4);  // Burst length is exact
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        resp_t      resp;
        logic [7:0] bad_code;
        spi_rst_      = 1'b0;
        datin_rst     = 1'b0;
        datin_trigger = 1'b0;
        datin_data    = '0;
        cmd_valid     = 1'b0;
        cmd_word      = '0;
        lfsr_state    = 32'h36b0;
        block_words   = 0;
        led_model     = '0;
        mode_model    = '0;
        $readmemh("bench/sd_readout_bridge_patterns.hex", pat_mem);
        repeat (ResetCycles) @(negedge sd_datInWrite_clk);
        spi_rst_ = 1'b1;
        @(negedge sd_datInWrite_clk);
        if (!datin_ready || readout_ready || readout_valid || resp_valid) begin
            note_failure("output levels after reset are wrong");
        end
        check_led("led", led, led_model);

        for (int i = 0; i < 2; i++) begin
            send_command(msg_echo, pat_mem[EchoBase + i][55:0], resp);
            check_resp("resp_word", resp, {8'h00, pat_mem[EchoBase + i][55:0]});
        end
        send_command(msg_nop, 56'h0, resp);
        check_resp("resp_word", resp, '0);

        for (int i = 0; i < 2; i++) begin
            send_command(msg_led_set, pat_mem[LedBase + i][55:0], resp);
            led_model = pat_mem[LedBase + i][3:0];  // LED view is the low nibble
            check_led("led", led, led_model);
            check_resp("resp_word", resp, '0);
        end
        send_command(msg_status, 56'h0, resp);
        check_resp("resp_word", resp, status_word(1'b1, 1'b0, 8'd0, mode_model));

        bad_code = pat_mem[BadTypeIdx][7:0];
        send_command(bad_code, 56'h0, resp);
        check_resp("resp_word", resp, {1'b1, 63'd0});
        check_led("led", led, led_model);

        // Fill every stage with no readout
        pulse_datin_rst();
        write_words(DataBase, DataWords);
        repeat (IdleChecks) begin
            @(negedge sd_datInWrite_clk);
            if (datin_ready) note_failure("datin_ready high with every stage full");
        end
        send_command(msg_status, 56'h0, resp);
        check_resp("resp_word", resp, status_word(1'b0, 1'b1, 8'(StageCount), mode_model));
        if (!readout_ready) note_failure("readout_ready low with every stage full");

        send_command(msg_readout, 56'h0, resp);
        check_resp("resp_word", resp, '0);
        collect_burst(BurstWords);
        write_words(ResumeBase, ResumeWords);     // Drained stages take words again
        send_command(msg_readout, 56'h0, resp);
        collect_burst(BurstWords);

        // One stage left is below the threshold
        repeat (2) @(negedge sd_datInWrite_clk);
        send_command(msg_status, 56'h0, resp);
        check_resp("resp_word", resp, status_word(1'b1, 1'b0, 8'd1, mode_model));
        if (readout_ready) note_failure("readout_ready high with one stage full");
        send_command(msg_readout, 56'h0, resp);
        expect_idle(IdleChecks);

        // New block whose word Cmd6WordIndex sets the access mode
        pulse_datin_rst();
        write_words(Cmd6Base, Cmd6Words);
        repeat (2) @(negedge sd_datInWrite_clk);
        send_command(msg_status, 56'h0, resp);
        check_resp("resp_word", resp, status_word(1'b1, 1'b0, 8'd1, mode_model));

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- logic/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder import sd_bridge_pkg::*; (
    input  logic         sd_datInWrite_clk,
    input  logic         spi_rst_,
    input  logic         cmd_valid,       // One-cycle strobe
    input  msg_t         cmd_word,
    input  access_mode_t access_mode,
    input  logic [7:0]   full_count,
    input  logic         datin_ready,
    input  logic         readout_ready,
    output logic         resp_valid,
    output resp_t        resp_word,
    output led_t         led,
    output logic         readout_start
);
    resp_t resp_next;
    logic  led_load;
    logic  start_req;

    // ====================
    // Decode
    // ====================
    always_comb begin
        resp_next = '0;
        led_load  = 1'b0;
        start_req = 1'b0;
        case (cmd_word.msg_type)
            msg_nop: begin
                resp_next = '0;
            end

            msg_echo: begin
                resp_next[55:0] = cmd_word.arg.echo.payload;
            end

            msg_led_set: begin
                led_load = 1'b1;  // Value taken from the LED view below
            end

            msg_status: begin
                resp_next[RespDatinReadyBit]   = datin_ready;
                resp_next[RespReadoutReadyBit] = readout_ready;
                resp_next[RespFullCountLsb +: 8] = full_count;
                resp_next[RespAccessModeLsb +: $bits(access_mode_t)] = access_mode;
            end

            // Drainer decides whether enough data is there
            msg_readout: begin
                start_req = 1'b1;
            end

            default: begin
                resp_next[RespErrBit] = 1'b1;  // Unknown type
            end
        endcase
    end

    // ====================
    // Response and LEDs
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            resp_valid    <= 1'b0;
            readout_start <= 1'b0;
            led           <= '0;
        end else begin
            resp_valid    <= cmd_valid;
            readout_start <= cmd_valid && start_req;
            if (cmd_valid && led_load) begin
                led <= cmd_word.arg.led_set.val;
            end
        end
    end

    // Payload, follows cmd_valid by one clock
    always_ff @(posedge sd_datInWrite_clk) begin
        if (cmd_valid) begin
            resp_word <= resp_next;
        end
    end

endmodule

//--- logic/datin_writer.sv
`timescale 1ns/100ps

module datin_writer import sd_bridge_pkg::*; #(
    parameter int StageCount = 8,
    parameter int StageWords = 16
) (
    input  logic                  sd_datInWrite_clk,
    input  logic                  spi_rst_,
    input  logic                  datin_rst,      // Block start
    input  logic                  datin_trigger,
    input  word_t                 datin_data,
    output logic                  datin_ready,
    input  logic [StageCount-1:0] stage_full,
    output logic [StageCount-1:0] stage_wr,       // One-hot
    output word_t                 stage_wr_data,
    output access_mode_t          access_mode
);
    localparam int PtrW     = $clog2(StageCount);
    localparam int CntW     = $clog2(StageWords + 1);
    localparam int Cmd6CntW = $clog2(Cmd6WordIndex + 2);

    logic [PtrW-1:0]     wr_ptr;       // Target stage
    logic [CntW-1:0]     tgt_cnt;      // Words written into the target
    logic [Cmd6CntW-1:0] cmd6_cnt;
    logic                accept;
    logic                target_done;

    // ====================
    // Stage steering
    // ====================
    assign datin_ready   = !datin_rst && !stage_full[wr_ptr];
    assign accept        = datin_trigger && datin_ready;
    assign target_done   = (tgt_cnt == CntW'(StageWords));
    assign stage_wr      = accept ? (StageCount'(1) << wr_ptr) : '0;
    assign stage_wr_data = datin_data;

    // Move on once the target reports full
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            wr_ptr  <= '0;
            tgt_cnt <= '0;
        end else if (datin_rst) begin
            wr_ptr  <= '0;
            tgt_cnt <= '0;
        end else if (target_done && stage_full[wr_ptr]) begin
            wr_ptr  <= (wr_ptr == PtrW'(StageCount - 1)) ? '0 : wr_ptr + 1'b1;
            tgt_cnt <= '0;
        end else if (accept) begin
            tgt_cnt <= tgt_cnt + 1'b1;
        end
    end

    // ====================
    // CMD6 access mode
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            cmd6_cnt    <= '0;
            access_mode <= '0;
        end else if (datin_rst) begin
            cmd6_cnt <= '0;
        end else if (accept) begin
            if (cmd6_cnt == Cmd6CntW'(Cmd6WordIndex)) begin
                access_mode <= datin_data[Cmd6NibbleLsb +: $bits(access_mode_t)];
            end
            if (cmd6_cnt <= Cmd6CntW'(Cmd6WordIndex)) begin
                cmd6_cnt <= cmd6_cnt + 1'b1;  // Saturates past the mode word
            end
        end
    end

    // The stage must report full right after its StageWords-th word
    a_full_after_fill: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_ || datin_rst)
        target_done |-> stage_full[wr_ptr]
    ) else $error("datin_writer: target stage not full after StageWords words");

endmodule

//--- logic/fifo_stage.sv
`timescale 1ns/100ps

module fifo_stage import sd_bridge_pkg::*; #(
    parameter int StageWords = 16
) (
    input  logic  sd_datInWrite_clk,
    input  logic  spi_rst_,
    input  logic  clear,    // Block start, empties the stage
    input  logic  wr,
    input  word_t wr_data,
    input  logic  rd,
    output word_t rd_data,
    output logic  full
);
    localparam int IdxW = $clog2(StageWords);
    localparam logic [IdxW-1:0] LastIdx = IdxW'(StageWords - 1);

    word_t           mem [StageWords];
    logic [IdxW-1:0] fill_idx;
    logic [IdxW-1:0] rd_idx;

    always_ff @(posedge sd_datInWrite_clk) begin
        if (wr) begin
            mem[fill_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];  // Word at the read index, taken when rd is high

    // Fill completely, then drain completely
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            fill_idx <= '0;
            rd_idx   <= '0;
            full     <= 1'b0;
        end else if (clear) begin
            fill_idx <= '0;
            rd_idx   <= '0;
            full     <= 1'b0;
        end else begin
            if (wr) begin
                fill_idx <= (fill_idx == LastIdx) ? '0 : fill_idx + 1'b1;
                if (fill_idx == LastIdx) full <= 1'b1;  // Last word in
            end
            if (rd) begin
                rd_idx <= (rd_idx == LastIdx) ? '0 : rd_idx + 1'b1;
                if (rd_idx == LastIdx) full <= 1'b0;    // Last word out
            end
        end
    end

    // Writer and drainer must respect the full flag
    a_no_wr_when_full: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        wr |-> !full
    ) else $error("fifo_stage: write while full");

    a_no_rd_when_empty: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        rd |-> full
    ) else $error("fifo_stage: read while not full");

endmodule

//--- logic/readout_drainer.sv
`timescale 1ns/100ps

module readout_drainer import sd_bridge_pkg::*; #(
    parameter int StageCount = 8,
    parameter int StageWords = 16,
    parameter int ReadThresh = StageCount / 2
) (
    input  logic                  sd_datInWrite_clk,
    input  logic                  spi_rst_,
    input  logic                  datin_rst,
    input  logic [StageCount-1:0] stage_full,
    output logic [StageCount-1:0] stage_rd,         // One-hot
    input  word_t                 stage_rd_data [StageCount],
    input  logic                  readout_start,
    output logic                  readout_ready,
    output logic                  readout_valid,
    output word_t                 readout_data,
    output logic [7:0]            full_count
);
    localparam int BurstWords = ReadThresh * StageWords;
    localparam int PtrW       = $clog2(StageCount);
    localparam int IdxW       = $clog2(StageWords);
    localparam int RemW       = $clog2(BurstWords + 1);

    logic            busy;
    logic [PtrW-1:0] rd_ptr;      // Oldest full stage
    logic [IdxW-1:0] word_idx;    // Position inside rd_ptr's stage
    logic [RemW-1:0] remaining;   // Words left in this burst
    logic            start_ok;

    // Full stage count
    always_comb begin
        full_count = '0;
        for (int i = 0; i < StageCount; i++) begin
            full_count = full_count + 8'(stage_full[i]);
        end
    end

    assign readout_ready = (full_count >= 8'(ReadThresh));
    assign start_ok      = readout_start && readout_ready && !busy;  // Otherwise dropped
    assign stage_rd      = busy ? (StageCount'(1) << rd_ptr) : '0;

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            busy          <= 1'b0;
            rd_ptr        <= '0;
            word_idx      <= '0;
            remaining     <= '0;
            readout_valid <= 1'b0;
        end else if (datin_rst) begin
            busy          <= 1'b0;
            rd_ptr        <= '0;
            word_idx      <= '0;
            remaining     <= '0;
            readout_valid <= 1'b0;
        end else begin
            readout_valid <= busy;
            if (start_ok) begin
                busy      <= 1'b1;
                remaining <= RemW'(BurstWords);
            end else if (busy) begin
                if (word_idx == IdxW'(StageWords - 1)) begin
                    word_idx <= '0;
                    rd_ptr   <= (rd_ptr == PtrW'(StageCount - 1)) ? '0 : rd_ptr + 1'b1;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
                remaining <= remaining - 1'b1;
                if (remaining == RemW'(1)) busy <= 1'b0;  // Burst done
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (busy) begin
            readout_data <= stage_rd_data[rd_ptr];
        end
    end

endmodule

//--- logic/sd_bridge_pkg.sv
package sd_bridge_pkg;

    // ====================
    // Basic types
    // ====================
    typedef logic [15:0] word_t;         // DatIn and readout word
    typedef logic [3:0]  led_t;
    typedef logic [3:0]  access_mode_t;  // CMD6 access mode nibble

    typedef enum logic [7:0] {
        msg_nop     = 8'h00,
        msg_echo    = 8'h01,
        msg_led_set = 8'h02,
        msg_status  = 8'h03,
        msg_readout = 8'h04
    } msg_type_t;

    // ====================
    // Command word
    // ====================
    typedef struct packed {
        logic [55:0] payload;  // Returned as is
    } echo_arg_t;

    typedef struct packed {
        logic [51:0] unused;
        led_t        val;
    } led_set_arg_t;

    // Same 56 argument bits, two views
    typedef union packed {
        echo_arg_t    echo;
        led_set_arg_t led_set;
    } msg_arg_u;

    typedef struct packed {
        msg_type_t msg_type;  // Top byte
        msg_arg_u  arg;
    } msg_t;

    typedef logic [63:0] resp_t;

    // Status fields, from the top of resp_t down
    localparam int RespErrBit          = 63;
    localparam int RespDatinReadyBit   = 62;
    localparam int RespReadoutReadyBit = 61;
    localparam int RespFullCountLsb    = 53;  // 8 bits, 60:53
    localparam int RespAccessModeLsb   = 49;  // 4 bits, 52:49

    // CMD6 switch-function block, word 8 carries the access mode in 11:8
    localparam int Cmd6WordIndex = 8;
    localparam int Cmd6NibbleLsb = 8;

endpackage

//--- logic/sd_readout_bridge.sv
`timescale 1ns/100ps

module sd_readout_bridge import sd_bridge_pkg::*; #(
    parameter int StageCount = 8,
    parameter int StageWords = 16,
    parameter int ReadThresh = StageCount / 2
) (
    input  logic  sd_datInWrite_clk,
    input  logic  spi_rst_,
    input  logic  datin_rst,
    input  logic  datin_trigger,
    input  word_t datin_data,
    output logic  datin_ready,
    input  logic  cmd_valid,
    input  msg_t  cmd_word,
    output logic  resp_valid,
    output resp_t resp_word,
    output led_t  led,
    output logic  readout_ready,
    output logic  readout_valid,
    output word_t readout_data
);
    logic [StageCount-1:0] stage_full;
    logic [StageCount-1:0] stage_wr;
    logic [StageCount-1:0] stage_rd;
    word_t                 stage_wr_data;
    word_t                 stage_rd_data [StageCount];
    access_mode_t          access_mode;
    logic [7:0]            full_count;
    logic                  readout_start;

    // ====================
    // DatIn side
    // ====================
    datin_writer #(
        .StageCount(StageCount),
        .StageWords(StageWords)
    ) datin_writer_i (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .datin_rst(datin_rst),
        .datin_trigger(datin_trigger),
        .datin_data(datin_data),
        .datin_ready(datin_ready),
        .stage_full(stage_full),
        .stage_wr(stage_wr),
        .stage_wr_data(stage_wr_data),
        .access_mode(access_mode)
    );

    // Stage array
    for (genvar i = 0; i < StageCount; i++) begin : g_stage
        fifo_stage #(
            .StageWords(StageWords)
        ) fifo_stage_i (
            .sd_datInWrite_clk(sd_datInWrite_clk),
            .spi_rst_(spi_rst_),
            .clear(datin_rst),
            .wr(stage_wr[i]),
            .wr_data(stage_wr_data),
            .rd(stage_rd[i]),
            .rd_data(stage_rd_data[i]),
            .full(stage_full[i])
        );
    end

    // ====================
    // Readout and commands
    // ====================
    readout_drainer #(
        .StageCount(StageCount),
        .StageWords(StageWords),
        .ReadThresh(ReadThresh)
    ) readout_drainer_i (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .datin_rst(datin_rst),
        .stage_full(stage_full),
        .stage_rd(stage_rd),
        .stage_rd_data(stage_rd_data),
        .readout_start(readout_start),
        .readout_ready(readout_ready),
        .readout_valid(readout_valid),
        .readout_data(readout_data),
        .full_count(full_count)
    );

    cmd_decoder cmd_decoder_i (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .spi_rst_(spi_rst_),
        .cmd_valid(cmd_valid),
        .cmd_word(cmd_word),
        .access_mode(access_mode),
        .full_count(full_count),
        .datin_ready(datin_ready),
        .readout_ready(readout_ready),
        .resp_valid(resp_valid),
        .resp_word(resp_word),
        .led(led),
        .readout_start(readout_start)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sd_readout_bridge -f sd_readout_bridge.f \
    -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vtb_sd_readout_bridge > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

//--- sd_readout_bridge.f
+incdir+include
logic/sd_bridge_pkg.sv
logic/fifo_stage.sv
logic/datin_writer.sv
logic/readout_drainer.sv
logic/cmd_decoder.sv
logic/sd_readout_bridge.sv
bench/tb_sd_readout_bridge.sv
